/* sim.f */
+incdir+tests
logic/bram_mode_pkg.sv
logic/bram_fifo_pkg.sv
logic/port_lane.sv
logic/fifo_ctl.sv
logic/dp_sram.sv
logic/bram_tile.sv
tests/bram_tile_tb.sv

/* run_sim.sh */
#!/bin/sh
# verilator build and run of the bram tile testbench
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f sim.f --top-module bram_tile_tb -o bram_tile_sim \
   && ./obj_dir/bram_tile_sim > sim.log 2>&1 \
   || echo "build or simulation run failed"
cat sim.log 2>/dev/null
grep -q "All checks passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

/* tests/bram_checks.svh */
`ifndef BRAM_CHECKS_SVH
`define BRAM_CHECKS_SVH

logic [DATA_W-1:0] ref_mem [WORDS]; // expected array contents

function automatic logic [31:0] xorshift32(input logic [31:0] x);
   logic [31:0] y;
   y = x ^ (x << 13);
   y = y ^ (y >> 17);
   return y ^ (y << 5);
endfunction

function automatic logic [DATA_W-1:0] next_data();
   rng = xorshift32(rng);
   return rng[DATA_W-1:0];
endfunction

function automatic int slot_width(input mode_t m);
   case (m)
      MODE_4:  return 4;
      MODE_2:  return 2;
      MODE_1:  return 1;
      default: return 9;
   endcase
endfunction

// word after a write of d at slot sub, narrow slots cover bits 15..0 only
function automatic logic [DATA_W-1:0] model_write(input logic [DATA_W-1:0] old,
      input mode_t m, input logic [3:0] sub, input logic [1:0] be,
      input logic [DATA_W-1:0] d);
   logic [DATA_W-1:0] w;
   int lo;
   w = old;
   lo = (int'(sub) / slot_width(m)) * slot_width(m);
   if (m == MODE_18) begin
      if (be[0])
         {w[16], w[7:0]} = {d[16], d[7:0]};
      if (be[1])
         {w[17], w[15:8]} = {d[17], d[15:8]};
   end else if (m == MODE_9) begin
      if (sub[3])
         {w[17], w[15:8]} = {d[16], d[7:0]}; // parity travels on bit 16
      else
         {w[16], w[7:0]} = {d[16], d[7:0]};
   end else begin
      for (int i = 0; i < slot_width(m); i++)
         w[lo + i] = d[i];
   end
   return w;
endfunction

function automatic logic [DATA_W-1:0] model_read(input logic [DATA_W-1:0] word,
      input mode_t m, input logic [3:0] sub);
   logic [DATA_W-1:0] r;
   int lo;
   r = '0;
   lo = (int'(sub) / slot_width(m)) * slot_width(m);
   if (m == MODE_18) begin
      r = word;
   end else if (m == MODE_9) begin
      if (sub[3])
         {r[16], r[7:0]} = {word[17], word[15:8]};
      else
         {r[16], r[7:0]} = {word[16], word[7:0]};
   end else begin
      for (int i = 0; i < slot_width(m); i++)
         r[i] = word[lo + i];
   end
   return r;
endfunction

// order matches the flags vector of the testbench
function automatic logic [7:0] flag_model(input int cnt, input logic ovr, input logic udr);
   logic [7:0] f;
   f[7] = (cnt == 0);
   f[6] = (cnt <= 1);
   f[5] = (cnt <= UPAE);
   f[4] = udr;
   f[3] = (cnt == FIFO_DEPTH);
   f[2] = (cnt >= FIFO_DEPTH - 1);
   f[1] = (cnt >= FIFO_DEPTH - UPAF);
   f[0] = ovr;
   return f;
endfunction

task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] want,
      input string what);
   if (got !== want) begin
      data_errs++;
      $display("[ERROR] %0t ns %s: read %h, expected %h", $time, what, got, want);
   end
endtask

task automatic check_flags(input logic [7:0] got, input logic [7:0] want, input string what);
   if (got !== want) begin
      flag_errs++;
      $display("[ERROR] %0t ns %s: flags %b, expected %b", $time, what, got, want);
   end
endtask

`endif

/* tests/bram_tile_tb.sv */
`timescale 1ns/1ps

module bram_tile_tb
   import bram_mode_pkg::*;
   import bram_fifo_pkg::*;
();

   localparam int CLK_PERIOD = 8;
   localparam int UPAF       = 16; // almost-full distance from depth
   localparam int UPAE       = 8;
   localparam int N_ORDER    = 32;
   // cycles per test, reset first
   localparam int TEST_CYCLES = 5 + 8 + 6 + 64 + 20 + 2 * N_ORDER
                                + FIFO_DEPTH + (FIFO_DEPTH + 8);
   localparam int MARGIN      = 100;

   logic              CLK_A_i = 1'b0;
   logic              RESET_ni;
   mode_t             RMODE_A_i, RMODE_B_i, WMODE_A_i, WMODE_B_i;
   logic              WEN_A_i, WEN_B_i, REN_A_i, REN_B_i;
   logic [1:0]        BE_A_i, BE_B_i;
   logic [ADDR_W-1:0] ADDR_A_i, ADDR_B_i;
   logic [DATA_W-1:0] WDATA_A_i, WDATA_B_i;
   logic [DATA_W-1:0] RDATA_A_o, RDATA_B_o;
   logic              FMODE_i, FLUSH_ni;
   logic [THR_W-1:0]  UPAF_i, UPAE_i;
   logic              EMPTY_o, EPO_o, EWM_o, UNDERRUN_o, FULL_o, FMO_o, FWM_o, OVERRUN_o;
   logic [7:0]        flags;
   logic [31:0]       rng;
   logic              ovr_m, udr_m;
   logic [DATA_W-1:0] fifo_q [$]; // words the fifo should hold
   int                data_errs, flag_errs;

   `include "bram_checks.svh"

   assign flags = {EMPTY_o, EPO_o, EWM_o, UNDERRUN_o, FULL_o, FMO_o, FWM_o, OVERRUN_o};

   bram_tile u_dut (.*);

   initial begin
      forever #(CLK_PERIOD / 2) CLK_A_i = ~CLK_A_i;
   end

   initial begin
      #(CLK_PERIOD * (TEST_CYCLES + MARGIN));
      $display("timeout: tests did not finish within %0d cycles", TEST_CYCLES + MARGIN);
      $display("Checks failed");
      $finish;
   end

   // all tasks start and end on a falling edge
   task automatic write_a(input mode_t m, input logic [ADDR_W-1:0] a, input logic [1:0] be,
         input logic [DATA_W-1:0] d);
      WMODE_A_i = m;
      ADDR_A_i  = a;
      BE_A_i    = be;
      WDATA_A_i = d;
      WEN_A_i   = 1'b1;
      @(negedge CLK_A_i);
      WEN_A_i = 1'b0;
      ref_mem[a[ADDR_W-1:4]] = model_write(ref_mem[a[ADDR_W-1:4]], m, a[3:0], be, d);
   endtask

   task automatic write_b(input mode_t m, input logic [ADDR_W-1:0] a, input logic [1:0] be,
         input logic [DATA_W-1:0] d);
      WMODE_B_i = m;
      ADDR_B_i  = a;
      BE_B_i    = be;
      WDATA_B_i = d;
      WEN_B_i   = 1'b1;
      @(negedge CLK_A_i);
      WEN_B_i = 1'b0;
      ref_mem[a[ADDR_W-1:4]] = model_write(ref_mem[a[ADDR_W-1:4]], m, a[3:0], be, d);
   endtask

   task automatic read_a(input mode_t m, input logic [ADDR_W-1:0] a, input string what);
      RMODE_A_i = m;
      ADDR_A_i  = a;
      REN_A_i   = 1'b1;
      @(negedge CLK_A_i);
      REN_A_i = 1'b0;
      check_data(RDATA_A_o, model_read(ref_mem[a[ADDR_W-1:4]], m, a[3:0]), what);
   endtask

   task automatic read_b(input mode_t m, input logic [ADDR_W-1:0] a, input string what);
      RMODE_B_i = m;
      ADDR_B_i  = a;
      REN_B_i   = 1'b1;
      @(negedge CLK_A_i);
      REN_B_i = 1'b0;
      check_data(RDATA_B_o, model_read(ref_mem[a[ADDR_W-1:4]], m, a[3:0]), what);
   endtask

   task automatic push_word(input logic [DATA_W-1:0] d);
      WDATA_A_i = d;
      WEN_A_i   = 1'b1;
      @(negedge CLK_A_i);
      WEN_A_i = 1'b0;
      if (fifo_q.size() == FIFO_DEPTH)
         ovr_m = 1'b1; // dropped
      else
         fifo_q.push_back(d);
      check_flags(flags, flag_model(fifo_q.size(), ovr_m, udr_m), "flags after push");
   endtask

   task automatic pop_word();
      logic [DATA_W-1:0] want;
      REN_B_i = 1'b1;
      @(negedge CLK_A_i);
      REN_B_i = 1'b0;
      if (fifo_q.size() == 0) begin
         udr_m = 1'b1;
      end else begin
         want = fifo_q.pop_front();
         check_data(RDATA_B_o, want, "fifo pop data");
      end
      check_flags(flags, flag_model(fifo_q.size(), ovr_m, udr_m), "flags after pop");
   endtask

   task automatic flush_fifo();
      FLUSH_ni = 1'b0;
      @(negedge CLK_A_i);
      FLUSH_ni = 1'b1;
      fifo_q.delete();
      ovr_m = 1'b0;
      udr_m = 1'b0;
      check_flags(flags, flag_model(0, 1'b0, 1'b0), "flags after flush");
   endtask

   task automatic full_width_rw();
      logic [ADDR_W-1:0] a;
      a = {10'd37, 4'd0};
      check_flags(flags, flag_model(0, 1'b0, 1'b0), "flags after reset");
      write_a(MODE_18, a, 2'b11, next_data());
      read_b(MODE_18, a, "full width read");
      for (int be = 1; be < 3; be++) begin
         write_a(MODE_18, a, 2'(be), next_data());
         read_b(MODE_18, a, "byte enable read");
      end
   endtask

   task automatic cross_port_rw();
      logic [ADDR_W-1:0] a;
      a = {10'd300, 4'd0};
      write_b(MODE_18, a, 2'b11, next_data());
      read_a(MODE_18, a, "port b word read on port a");
      write_b(MODE_9, {10'd300, 4'd8}, 2'b11, next_data());
      read_a(MODE_9, {10'd300, 4'd8}, "port b 9-bit slot read on port a");
      read_a(MODE_18, a, "port b 9-bit write read as word");
   endtask

   task automatic narrow_slots();
      mode_t modes [4];
      int    step;
      modes = '{MODE_9, MODE_4, MODE_2, MODE_1};
      foreach (modes[k]) begin
         step = (modes[k] == MODE_9) ? 8 : slot_width(modes[k]);
         for (int s = 0; s < 16; s += step)
            write_a(modes[k], {10'd100, 4'(s)}, 2'b11, next_data());
         for (int s = 0; s < 16; s += step)
            read_b(modes[k], {10'd100, 4'(s)}, "narrow slot read");
      end
   endtask

   task automatic mixed_modes();
      write_a(MODE_18, {10'd200, 4'd0}, 2'b11, next_data()); // defines parity bits
      for (int s = 0; s < 16; s++)
         write_a(MODE_1, {10'd200, 4'(s)}, 2'b11, next_data());
      read_b(MODE_18, {10'd200, 4'd0}, "1-bit writes read as word");
   endtask

   task automatic fifo_order();
      FMODE_i   = 1'b1;
      // user side settings that fifo mode overrides
      BE_A_i    = 2'b00;
      WMODE_A_i = MODE_1;
      RMODE_B_i = MODE_4;
      WEN_B_i   = 1'b1;
      WDATA_B_i = '1;
      for (int i = 0; i < N_ORDER; i++)
         push_word(next_data());
      for (int i = 0; i < N_ORDER; i++)
         pop_word();
   endtask

   task automatic fifo_levels();
      for (int i = 0; i < FIFO_DEPTH; i++)
         push_word(next_data());
   endtask

   task automatic fifo_error_flags();
      push_word(next_data()); // at full
      for (int i = 0; i < FIFO_DEPTH; i++)
         pop_word();
      pop_word(); // at empty
      push_word(next_data());
      push_word(next_data()); // count the flush has to clear
      flush_fifo();
   endtask

   initial begin
      RESET_ni  = 1'b0;
      RMODE_A_i = MODE_18;
      RMODE_B_i = MODE_18;
      WMODE_A_i = MODE_18;
      WMODE_B_i = MODE_18;
      WEN_A_i   = 1'b0;
      WEN_B_i   = 1'b0;
      REN_A_i   = 1'b0;
      REN_B_i   = 1'b0;
      BE_A_i    = 2'b11;
      BE_B_i    = 2'b11;
      ADDR_A_i  = '0;
      ADDR_B_i  = '0;
      WDATA_A_i = '0;
      WDATA_B_i = '0;
      FMODE_i   = 1'b0;
      FLUSH_ni  = 1'b1;
      UPAF_i    = THR_W'(UPAF);
      UPAE_i    = THR_W'(UPAE);
      rng       = 32'd55;
      ovr_m     = 1'b0;
      udr_m     = 1'b0;
      data_errs = 0;
      flag_errs = 0;
      repeat (4) @(negedge CLK_A_i);
      RESET_ni = 1'b1;
      @(negedge CLK_A_i);
      full_width_rw();
      cross_port_rw();
      narrow_slots();
      mixed_modes();
      fifo_order();
      fifo_levels();
      fifo_error_flags();
      $display("data errors: %0d, flag errors: %0d", data_errs, flag_errs);
      if (data_errs == 0 && flag_errs == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

/* logic/bram_tile.sv */
`timescale 1ns/1ps

module bram_tile
   import bram_mode_pkg::*;
   import bram_fifo_pkg::*;
(
   input  logic              CLK_A_i,
   input  logic              RESET_ni,
   input  mode_t             RMODE_A_i,
   input  mode_t             RMODE_B_i,
   input  mode_t             WMODE_A_i,
   input  mode_t             WMODE_B_i,
   input  logic              WEN_A_i,
   input  logic              WEN_B_i,
   input  logic              REN_A_i,
   input  logic              REN_B_i,
   input  logic [1:0]        BE_A_i,
   input  logic [1:0]        BE_B_i,
   input  logic [ADDR_W-1:0] ADDR_A_i,
   input  logic [ADDR_W-1:0] ADDR_B_i,
   input  logic [DATA_W-1:0] WDATA_A_i,
   input  logic [DATA_W-1:0] WDATA_B_i,
   output logic [DATA_W-1:0] RDATA_A_o,
   output logic [DATA_W-1:0] RDATA_B_o,
   input  logic              FMODE_i,
   input  logic              FLUSH_ni,
   input  logic [THR_W-1:0]  UPAF_i,
   input  logic [THR_W-1:0]  UPAE_i,
   output logic              EMPTY_o,
   output logic              EPO_o,
   output logic              EWM_o,
   output logic              UNDERRUN_o,
   output logic              FULL_o,
   output logic              FMO_o,
   output logic              FWM_o,
   output logic              OVERRUN_o
);

   logic               wen_a, ren_a, wen_b, ren_b;
   logic [ADDR_W-1:0]  addr_a, addr_b;
   logic [1:0]         be_a;
   mode_t              wmode_a, rmode_a, wmode_b, rmode_b;
   logic               push, pop, pop_ok;
   logic [PTR_W-1:0]   ff_waddr, ff_raddr;
   logic [WORD_AW-1:0] ram_addr_a, ram_addr_b;
   logic [DATA_W-1:0]  ram_wdata_a, ram_wdata_b;
   logic [DATA_W-1:0]  ram_wmask_a, ram_wmask_b;
   logic [DATA_W-1:0]  ram_rdata_a, ram_rdata_b;

   assign push = FMODE_i & WEN_A_i;
   assign pop  = FMODE_i & REN_B_i;

   // fifo takes over port A writes and port B reads
   assign wen_a   = FMODE_i ? (WEN_A_i & ~FULL_o) : WEN_A_i;
   assign ren_a   = FMODE_i ? 1'b0 : REN_A_i;
   assign wen_b   = FMODE_i ? 1'b0 : WEN_B_i;
   assign ren_b   = FMODE_i ? pop_ok : REN_B_i;
   assign addr_a  = FMODE_i ? {ff_waddr, {SUB_W{1'b0}}} : ADDR_A_i;
   assign addr_b  = FMODE_i ? {ff_raddr, {SUB_W{1'b0}}} : ADDR_B_i;
   assign be_a    = FMODE_i ? 2'b11 : BE_A_i;
   assign wmode_a = FMODE_i ? MODE_18 : WMODE_A_i;
   assign rmode_a = FMODE_i ? MODE_18 : RMODE_A_i;
   assign wmode_b = FMODE_i ? MODE_18 : WMODE_B_i;
   assign rmode_b = FMODE_i ? MODE_18 : RMODE_B_i;

   port_lane u_lane_a (
      .CLK_A_i     (CLK_A_i),
      .RESET_ni    (RESET_ni),
      .wen_i       (wen_a),
      .ren_i       (ren_a),
      .wmode_i     (wmode_a),
      .rmode_i     (rmode_a),
      .addr_i      (addr_a),
      .be_i        (be_a),
      .wdata_i     (WDATA_A_i),
      .word_addr_o (ram_addr_a),
      .wdata_o     (ram_wdata_a),
      .wmask_o     (ram_wmask_a),
      .ram_rdata_i (ram_rdata_a),
      .rdata_o     (RDATA_A_o)
   );

   port_lane u_lane_b (
      .CLK_A_i     (CLK_A_i),
      .RESET_ni    (RESET_ni),
      .wen_i       (wen_b),
      .ren_i       (ren_b),
      .wmode_i     (wmode_b),
      .rmode_i     (rmode_b),
      .addr_i      (addr_b),
      .be_i        (BE_B_i),
      .wdata_i     (WDATA_B_i),
      .word_addr_o (ram_addr_b),
      .wdata_o     (ram_wdata_b),
      .wmask_o     (ram_wmask_b),
      .ram_rdata_i (ram_rdata_b),
      .rdata_o     (RDATA_B_o)
   );

   fifo_ctl u_fifo_ctl (
      .CLK_A_i    (CLK_A_i),
      .RESET_ni   (RESET_ni),
      .flush_ni   (FLUSH_ni),
      .push_i     (push),
      .pop_i      (pop),
      .upaf_i     (UPAF_i),
      .upae_i     (UPAE_i),
      .waddr_o    (ff_waddr),
      .raddr_o    (ff_raddr),
      .pop_ok_o   (pop_ok),
      .empty_o    (EMPTY_o),
      .epo_o      (EPO_o),
      .ewm_o      (EWM_o),
      .underrun_o (UNDERRUN_o),
      .full_o     (FULL_o),
      .fmo_o      (FMO_o),
      .fwm_o      (FWM_o),
      .overrun_o  (OVERRUN_o)
   );

   dp_sram u_sram (
      .CLK_A_i   (CLK_A_i),
      .RESET_ni  (RESET_ni),
      .cen_a_i   (wen_a | ren_a),
      .wen_a_i   (wen_a),
      .addr_a_i  (ram_addr_a),
      .wdata_a_i (ram_wdata_a),
      .wmask_a_i (ram_wmask_a),
      .rdata_a_o (ram_rdata_a),
      .cen_b_i   (wen_b | ren_b),
      .wen_b_i   (wen_b),
      .addr_b_i  (ram_addr_b),
      .wdata_b_i (ram_wdata_b),
      .wmask_b_i (ram_wmask_b),
      .rdata_b_o (ram_rdata_b)
   );

endmodule

/* logic/dp_sram.sv */
`timescale 1ns/1ps

module dp_sram
   import bram_mode_pkg::*;
(
   input  logic               CLK_A_i,
   input  logic               RESET_ni,
   input  logic               cen_a_i,
   input  logic               wen_a_i,
   input  logic [WORD_AW-1:0] addr_a_i,
   input  logic [DATA_W-1:0]  wdata_a_i,
   input  logic [DATA_W-1:0]  wmask_a_i,
   output logic [DATA_W-1:0]  rdata_a_o,
   input  logic               cen_b_i,
   input  logic               wen_b_i,
   input  logic [WORD_AW-1:0] addr_b_i,
   input  logic [DATA_W-1:0]  wdata_b_i,
   input  logic [DATA_W-1:0]  wmask_b_i,
   output logic [DATA_W-1:0]  rdata_b_o
);

   logic [DATA_W-1:0] mem [WORDS];

   // bit granular so both ports can share a word
   always_ff @(posedge CLK_A_i) begin
      for (int i = 0; i < DATA_W; i++) begin
         if (cen_a_i && wen_a_i && !wmask_a_i[i])
            mem[addr_a_i][i] <= wdata_a_i[i];
         if (cen_b_i && wen_b_i && !wmask_b_i[i])
            mem[addr_b_i][i] <= wdata_b_i[i];
      end
   end

   always_ff @(posedge CLK_A_i or negedge RESET_ni) begin
      if (!RESET_ni) begin
         rdata_a_o <= '0;
         rdata_b_o <= '0;
      end else begin
         if (cen_a_i && !wen_a_i)
            rdata_a_o <= mem[addr_a_i]; // old data on collision
         if (cen_b_i && !wen_b_i)
            rdata_b_o <= mem[addr_b_i];
      end
   end

endmodule

/* logic/fifo_ctl.sv */
`timescale 1ns/1ps

module fifo_ctl
   import bram_fifo_pkg::*;
(
   input  logic             CLK_A_i,
   input  logic             RESET_ni,
   input  logic             flush_ni,
   input  logic             push_i,
   input  logic             pop_i,
   input  logic [THR_W-1:0] upaf_i,
   input  logic [THR_W-1:0] upae_i,
   output logic [PTR_W-1:0] waddr_o,
   output logic [PTR_W-1:0] raddr_o,
   output logic             pop_ok_o,
   output logic             empty_o,
   output logic             epo_o,
   output logic             ewm_o,
   output logic             underrun_o,
   output logic             full_o,
   output logic             fmo_o,
   output logic             fwm_o,
   output logic             overrun_o
);

   logic [CNT_W-1:0] cnt;
   logic [CNT_W-1:0] cnt_nxt;
   logic [CNT_W-1:0] fwm_lvl;
   logic [PTR_W-1:0] wptr_nxt;
   logic [PTR_W-1:0] rptr_nxt;
   logic             push_ok;
   logic             clr;

   assign clr      = ~flush_ni;
   assign push_ok  = push_i & ~full_o;  // dropped when full
   assign pop_ok_o = pop_i & ~empty_o;
   assign fwm_lvl  = CNT_W'(FIFO_DEPTH) - CNT_W'(upaf_i);

   always_comb begin
      if (clr) begin
         cnt_nxt  = '0;
         wptr_nxt = '0;
         rptr_nxt = '0;
      end else begin
         cnt_nxt  = cnt + CNT_W'(push_ok) - CNT_W'(pop_ok_o);
         wptr_nxt = waddr_o + PTR_W'(push_ok);
         rptr_nxt = raddr_o + PTR_W'(pop_ok_o);
      end
   end

   // flags follow the new count, so they show one cycle after the access
   always_ff @(posedge CLK_A_i or negedge RESET_ni) begin
      if (!RESET_ni) begin
         cnt        <= '0;
         waddr_o    <= '0;
         raddr_o    <= '0;
         empty_o    <= 1'b1;
         epo_o      <= 1'b1;
         ewm_o      <= 1'b1;
         full_o     <= 1'b0;
         fmo_o      <= 1'b0;
         fwm_o      <= 1'b0;
         overrun_o  <= 1'b0;
         underrun_o <= 1'b0;
      end else begin
         cnt        <= cnt_nxt;
         waddr_o    <= wptr_nxt;
         raddr_o    <= rptr_nxt;
         empty_o    <= (cnt_nxt == '0);
         epo_o      <= (cnt_nxt <= CNT_W'(1));
         ewm_o      <= (cnt_nxt <= CNT_W'(upae_i));
         full_o     <= (cnt_nxt == CNT_W'(FIFO_DEPTH));
         fmo_o      <= (cnt_nxt >= CNT_W'(FIFO_DEPTH - 1));
         fwm_o      <= (cnt_nxt >= fwm_lvl);
         overrun_o  <= ~clr & (overrun_o | (push_i & full_o));  // sticky
         underrun_o <= ~clr & (underrun_o | (pop_i & empty_o));
      end
   end

endmodule

/* logic/port_lane.sv */
`timescale 1ns/1ps

module port_lane
   import bram_mode_pkg::*;
(
   input  logic              CLK_A_i,
   input  logic              RESET_ni,
   input  logic              wen_i,
   input  logic              ren_i,
   input  mode_t             wmode_i,
   input  mode_t             rmode_i,
   input  logic [ADDR_W-1:0] addr_i,
   input  logic [1:0]        be_i,
   input  logic [DATA_W-1:0] wdata_i,
   output logic [WORD_AW-1:0] word_addr_o,
   output logic [DATA_W-1:0] wdata_o,
   output logic [DATA_W-1:0] wmask_o,
   input  logic [DATA_W-1:0] ram_rdata_i,
   output logic [DATA_W-1:0] rdata_o
);

   logic [SUB_W-1:0] sub_w;
   logic [SUB_W-1:0] sub_q;
   mode_t            rmode_q;
   logic             rd_cyc;

   assign word_addr_o = addr_i[ADDR_W-1:SUB_W];
   assign sub_w       = addr_i[SUB_W-1:0];
   assign rd_cyc      = ren_i & ~wen_i; // same read qualifier as the array

   // replicate narrow data across the word
   always_comb begin
      wdata_o = '0;
      if (wen_i) begin
         case (wmode_i)
            MODE_18: wdata_o = wdata_i;
            MODE_9:  wdata_o = {{2{wdata_i[16]}}, {2{wdata_i[BYTE_W-1:0]}}};
            MODE_4:  wdata_o = {2'b00, {4{wdata_i[3:0]}}};
            MODE_2:  wdata_o = {2'b00, {8{wdata_i[1:0]}}};
            MODE_1:  wdata_o = {2'b00, {16{wdata_i[0]}}};
            default: wdata_o = '0;
         endcase
      end
   end

   // mask bit 1 keeps the stored bit
   always_comb begin
      wmask_o = '1;
      if (wen_i) begin
         case (wmode_i)
            MODE_18: begin
               {wmask_o[17], wmask_o[15:8]} = {9{~be_i[1]}};
               {wmask_o[16], wmask_o[7:0]}  = {9{~be_i[0]}};
            end
            MODE_9: begin
               // upper half when addr bit 3 is set
               {wmask_o[17], wmask_o[15:8]} = {9{~sub_w[3]}};
               {wmask_o[16], wmask_o[7:0]}  = {9{sub_w[3]}};
            end
            MODE_4: begin
               wmask_o[{sub_w[3:2], 2'b00} +: 4] = 4'h0;
            end
            MODE_2: begin
               wmask_o[{sub_w[3:1], 1'b0} +: 2] = 2'h0;
            end
            MODE_1: begin
               wmask_o[sub_w] = 1'b0;
            end
            default: wmask_o = '1;
         endcase
      end
   end

   // slot select follows the data register in the array
   always_ff @(posedge CLK_A_i or negedge RESET_ni) begin
      if (!RESET_ni) begin
         sub_q   <= '0;
         rmode_q <= MODE_18;
      end else if (rd_cyc) begin
         sub_q   <= sub_w;
         rmode_q <= rmode_i;
      end
   end

   always_comb begin
      rdata_o = '0;
      case (rmode_q)
         MODE_18: begin
            rdata_o = ram_rdata_i;
         end
         MODE_9: begin
            if (sub_q[3])
               {rdata_o[16], rdata_o[7:0]} = {ram_rdata_i[17], ram_rdata_i[15:8]};
            else
               {rdata_o[16], rdata_o[7:0]} = {ram_rdata_i[16], ram_rdata_i[7:0]};
         end
         MODE_4: begin
            rdata_o[3:0] = ram_rdata_i[{sub_q[3:2], 2'b00} +: 4];
         end
         MODE_2: begin
            rdata_o[1:0] = ram_rdata_i[{sub_q[3:1], 1'b0} +: 2];
         end
         MODE_1: begin
            rdata_o[0] = ram_rdata_i[sub_q];
         end
         default: rdata_o = '0;
      endcase
   end

endmodule

/* logic/bram_fifo_pkg.sv */
package bram_fifo_pkg;

   // fifo mode always runs at 18 bit width, one entry per array word
   localparam int FIFO_DEPTH = 1024;

   localparam int PTR_W = 10; // wraps at depth
   localparam int CNT_W = 11; // holds 0..FIFO_DEPTH

   // programmable almost-full / almost-empty levels
   localparam int THR_W = 11;

endpackage

/* logic/bram_mode_pkg.sv */
package bram_mode_pkg;

   // port width mode encoding
   typedef logic [2:0] mode_t;

   localparam mode_t MODE_18 = 3'b010;
   localparam mode_t MODE_9  = 3'b001;
   localparam mode_t MODE_4  = 3'b100;
   localparam mode_t MODE_2  = 3'b110;
   localparam mode_t MODE_1  = 3'b101;

   localparam int DATA_W  = 18; // full port word incl. 2 parity bits
   localparam int ADDR_W  = 14; // port address in bit units
   localparam int WORD_AW = 10; // array word address, addr[13:4]

   // offset of a narrow slot inside one word
   localparam int SUB_W = ADDR_W - WORD_AW;

   // words in the array
   localparam int WORDS = 1 << WORD_AW;

   // data bits per byte lane, parity bits sit at 17 and 16
   localparam int BYTE_W = 8;

endpackage
